// File: common/dac_if_pkg.sv
package dac_if_pkg;

   // Width of one I or Q sample, also the DAC word width
   localparam int SAMPLE_W = 16;

   // Half of a DAC word, sent on each edge of the 2x clock
   localparam int BYTE_W = 8;

   // Gain is Q2.14, so 1.0 is 16384
   localparam int GAIN_W = 16;
   localparam int GAIN_FRAC = 14;

   // Full precision width of sample times gain
   localparam int PROD_W = SAMPLE_W + GAIN_W;

   // One baseband sample
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // One byte on the LVDS data pins
   typedef logic [BYTE_W-1:0] dac_byte_t;

   // Static channel gain
   typedef logic signed [GAIN_W-1:0] gain_t;

   // Raw multiplier result before rounding
   typedef logic signed [PROD_W-1:0] product_t;

   // Clamp limits of the DAC word
   localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
   localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

endpackage

// File: common/tx_ctrl_pkg.sv
package tx_ctrl_pkg;

   // Credit and FIFO fill counter, enough for a depth of 16
   localparam int CREDIT_W = 5;
   typedef logic [CREDIT_W-1:0] credit_t;

   // Extra 2x words that frame stays high during a DAC sync
   localparam int SYNC_CYCLES = 4;

   // Counter for the stretch, must hold SYNC_CYCLES
   localparam int SYNC_CNT_W = 3;
   typedef logic [SYNC_CNT_W-1:0] sync_cnt_t;

   // Sync sequence in the 2x domain
   //   SYNC_IDLE    no request pending
   //   SYNC_ARMED   request seen, waiting for the I phase
   //   SYNC_STRETCH frame forced high
   typedef enum logic [1:0]
   {
      SYNC_IDLE,
      SYNC_ARMED,
      SYNC_STRETCH
   } sync_state_t;

endpackage

// File: source/sample_credit_rx.sv
`timescale 1ns/1ps

module sample_credit_rx
   import dac_if_pkg::*, tx_ctrl_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
)
(
   input  logic    tx_clk_1x,
   input  logic    reset,
   // Host write side, one sample per credit
   input  logic    i_s_valid,
   input  sample_t i_s_i,
   input  sample_t i_s_q,
   // Sample pair towards the scaler
   output sample_t o_i,
   output sample_t o_q,
   // One pulse per popped sample
   output logic    o_credit,
   // Pulse when the stream runs dry
   output logic    o_underrun
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

   // Sample storage, one array per channel
   sample_t          mem_i [FIFO_DEPTH];
   sample_t          mem_q [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   credit_t          fill;
   logic             pop;

   // DAC drains at a fixed rate, pop whenever anything is stored
   // A write in this cycle is only visible to the next pop
   assign pop = (fill != credit_t'(0));

   // Storage write, the host never writes without a credit
   always_ff @(posedge tx_clk_1x)
   begin
      if (i_s_valid)
      begin
         mem_i[wr_ptr] <= i_s_i;
         mem_q[wr_ptr] <= i_s_q;
      end
   end

   // Pointers wrap at the depth, which need not be a power of two
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (i_s_valid)
            wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
   end

   // Occupancy count
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
         fill <= '0;
      else
      begin
         case ({i_s_valid, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // Output register
   // Empty cycles send zeros to the DAC
   // Underrun fires once, on the first empty cycle after a pop
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         o_i        <= '0;
         o_q        <= '0;
         o_credit   <= 1'b0;
         o_underrun <= 1'b0;
      end
      else
      begin
         o_i        <= pop ? mem_i[rd_ptr] : '0;
         o_q        <= pop ? mem_q[rd_ptr] : '0;
         o_credit   <= pop;
         // o_credit still holds last cycle's pop here
         o_underrun <= ~pop & o_credit;
      end
   end

endmodule

// File: source/iq_gain_scaler.sv
`timescale 1ns/1ps

module iq_gain_scaler
   import dac_if_pkg::*;
(
   input  logic    tx_clk_1x,
   input  logic    reset,
   // Static gains, Q2.14
   input  gain_t   i_gain_i,
   input  gain_t   i_gain_q,
   // Samples from the FIFO
   input  sample_t i_i,
   input  sample_t i_q,
   // Scaled samples, two cycles after the input
   output sample_t o_i,
   output sample_t o_q
);

   // Half an output LSB in product units
   localparam product_t ROUND_HALF = product_t'(2 ** (GAIN_FRAC - 1));

   product_t prod_i;
   product_t prod_q;

   // Round half up, drop the fraction, clamp to 16 bits
   function automatic sample_t round_sat(input product_t prod);
      product_t rounded;
      sample_t  result;
      rounded = (prod + ROUND_HALF) >>> GAIN_FRAC;
      if (rounded > product_t'(SAMPLE_MAX))
         result = SAMPLE_MAX;
      else if (rounded < product_t'(SAMPLE_MIN))
         result = SAMPLE_MIN;
      else
         result = rounded[SAMPLE_W-1:0];
      return result;
   endfunction

   // Stage one, full precision signed products
   // Both operands signed, so the product is sign extended to 32 bits
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         prod_i <= '0;
         prod_q <= '0;
      end
      else
      begin
         prod_i <= i_i * i_gain_i;
         prod_q <= i_q * i_gain_q;
      end
   end

   // Stage two, rounding and saturation
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         o_i <= '0;
         o_q <= '0;
      end
      else
      begin
         o_i <= round_sat(prod_i);
         o_q <= round_sat(prod_q);
      end
   end

endmodule

// File: ddr_lvds/frame_sync_gen.sv
`timescale 1ns/1ps

module frame_sync_gen
   import tx_ctrl_pkg::*;
(
   input  logic tx_clk_1x,
   input  logic tx_clk_2x,
   input  logic reset,
   // Rising edge starts one frame stretch
   input  logic i_sync_dacs,
   // High on the I word, 2x domain
   output logic o_frame
);

   logic        phase;
   logic        phase_2x;
   logic        clk_1x_high;
   logic        reset_2x;
   logic        sync_d;
   logic        sync_req;
   sync_state_t state;
   sync_cnt_t   sync_cnt;

   // Toggle once per 1x cycle so the 2x side can see the 1x phase
   // Sync edge detect also runs on the 1x clock
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         phase    <= 1'b0;
         sync_d   <= 1'b0;
         sync_req <= 1'b0;
      end
      else
      begin
         phase    <= ~phase;
         sync_d   <= i_sync_dacs;
         sync_req <= i_sync_dacs & ~sync_d;
      end
   end

   // Phase resample and reset pipeline into the 2x domain
   always_ff @(posedge tx_clk_2x)
   begin
      phase_2x <= phase;
      reset_2x <= reset;
   end

   // Two equal samples of phase in a row means the 1x clock
   // is in its high half for the next 2x cycle
   // Phase stands still in reset, so no phase is recovered until the 2x reset lifts
   always_ff @(posedge tx_clk_2x)
   begin
      if (reset_2x)
         clk_1x_high <= 1'b0;
      else
         clk_1x_high <= (phase == phase_2x);
   end

   // Frame marks the word sent in the first half of each 1x cycle
   // A sync holds it for SYNC_CYCLES more words
   // sync_req lasts two 2x cycles, the FSM has left IDLE before it drops
   always_ff @(posedge tx_clk_2x)
   begin
      if (reset_2x)
      begin
         state    <= SYNC_IDLE;
         sync_cnt <= '0;
         o_frame  <= 1'b0;
      end
      else
      begin
         o_frame <= clk_1x_high | (state == SYNC_STRETCH);
         case (state)
            SYNC_IDLE:
            begin
               if (sync_req)
                  state <= SYNC_ARMED;
            end
            SYNC_ARMED:
            begin
               // Start on an I word so the stretch covers five words
               if (clk_1x_high)
               begin
                  sync_cnt <= sync_cnt_t'(SYNC_CYCLES);
                  state    <= SYNC_STRETCH;
               end
            end
            SYNC_STRETCH:
            begin
               sync_cnt <= sync_cnt - 1'b1;
               if (sync_cnt == sync_cnt_t'(1))
                  state <= SYNC_IDLE;
            end
            default:
               state <= SYNC_IDLE;
         endcase
      end
   end

endmodule

// File: ddr_lvds/ddr_lvds_tx.sv
`timescale 1ns/1ps

module ddr_lvds_tx
   import dac_if_pkg::*;
(
   input  logic      tx_clk_1x,
   input  logic      tx_clk_2x,
   input  logic      reset,
   input  sample_t   i_i,
   input  sample_t   i_q,
   input  logic      i_sync_dacs,
   // Forwarded 2x clock
   output logic      o_tx_clk_p,
   output logic      o_tx_clk_n,
   // Frame, high on the I word
   output logic      o_tx_frame_p,
   output logic      o_tx_frame_n,
   // Data, I high, I low, Q high, Q low
   output dac_byte_t o_tx_d_p,
   output dac_byte_t o_tx_d_n
);

   // DDR lanes, data bytes then frame then clock
   localparam int FRAME_BIT = BYTE_W;
   localparam int CLK_BIT = BYTE_W + 1;
   localparam int LANE_W = BYTE_W + 2;

   sample_t           i_reg;
   sample_t           q_reg;
   sample_t           i_2x;
   sample_t           q_2x;
   sample_t           word_2x;
   logic              frame;
   logic [LANE_W-1:0] ddr_d1;
   logic [LANE_W-1:0] ddr_d2;
   logic [LANE_W-1:0] ddr_d1_q;
   logic [LANE_W-1:0] ddr_d2_q;
   logic [LANE_W-1:0] ddr_out;

   frame_sync_gen u_frame_sync_gen (
      .tx_clk_1x   (tx_clk_1x),
      .tx_clk_2x   (tx_clk_2x),
      .reset       (reset),
      .i_sync_dacs (i_sync_dacs),
      .o_frame     (frame)
   );

   // Plain register before the domain jump, no logic on the crossing
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         i_reg <= '0;
         q_reg <= '0;
      end
      else
      begin
         i_reg <= i_i;
         q_reg <= i_q;
      end
   end

   // 2x copy is stable across the I and Q words of one pair
   always_ff @(posedge tx_clk_2x)
   begin
      i_2x <= i_reg;
      q_2x <= q_reg;
   end

   assign word_2x = frame ? i_2x : q_2x;

   // Rising edge data, clock lane sends 1 then 0
   assign ddr_d1 = {1'b1, frame, word_2x[SAMPLE_W-1 -: BYTE_W]};
   assign ddr_d2 = {1'b0, frame, word_2x[BYTE_W-1:0]};

   // Same-edge output DDR, both halves captured on the rising edge
   always_ff @(posedge tx_clk_2x)
   begin
      ddr_d1_q <= ddr_d1;
      ddr_d2_q <= ddr_d2;
   end

   // First half while the clock is high, second half while low
   assign ddr_out = tx_clk_2x ? ddr_d1_q : ddr_d2_q;

   // Differential pairs
   assign o_tx_d_p     = ddr_out[BYTE_W-1:0];
   assign o_tx_d_n     = ~ddr_out[BYTE_W-1:0];
   assign o_tx_frame_p = ddr_out[FRAME_BIT];
   assign o_tx_frame_n = ~ddr_out[FRAME_BIT];
   assign o_tx_clk_p   = ddr_out[CLK_BIT];
   assign o_tx_clk_n   = ~ddr_out[CLK_BIT];

endmodule

// File: source/dac_tx_top.sv
`timescale 1ns/1ps

module dac_tx_top
   import dac_if_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
)
(
   input  logic      tx_clk_1x,
   input  logic      tx_clk_2x,
   input  logic      reset,
   // Host sample stream
   input  logic      i_s_valid,
   input  sample_t   i_s_i,
   input  sample_t   i_s_q,
   // Static gains
   input  gain_t     i_gain_i,
   input  gain_t     i_gain_q,
   input  logic      i_sync_dacs,
   // Flow control back to the host
   output logic      o_credit,
   output logic      o_underrun,
   // LVDS pins to the DAC
   output logic      o_tx_clk_p,
   output logic      o_tx_clk_n,
   output logic      o_tx_frame_p,
   output logic      o_tx_frame_n,
   output dac_byte_t o_tx_d_p,
   output dac_byte_t o_tx_d_n
);

   sample_t fifo_i;
   sample_t fifo_q;
   sample_t scaled_i;
   sample_t scaled_q;

   // Input FIFO with credit return
   sample_credit_rx #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_sample_credit_rx (
      .tx_clk_1x  (tx_clk_1x),
      .reset      (reset),
      .i_s_valid  (i_s_valid),
      .i_s_i      (i_s_i),
      .i_s_q      (i_s_q),
      .o_i        (fifo_i),
      .o_q        (fifo_q),
      .o_credit   (o_credit),
      .o_underrun (o_underrun)
   );

   // Gain, round, saturate
   iq_gain_scaler u_iq_gain_scaler (
      .tx_clk_1x (tx_clk_1x),
      .reset     (reset),
      .i_gain_i  (i_gain_i),
      .i_gain_q  (i_gain_q),
      .i_i       (fifo_i),
      .i_q       (fifo_q),
      .o_i       (scaled_i),
      .o_q       (scaled_q)
   );

   // DDR LVDS output
   ddr_lvds_tx u_ddr_lvds_tx (
      .tx_clk_1x    (tx_clk_1x),
      .tx_clk_2x    (tx_clk_2x),
      .reset        (reset),
      .i_i          (scaled_i),
      .i_q          (scaled_q),
      .i_sync_dacs  (i_sync_dacs),
      .o_tx_clk_p   (o_tx_clk_p),
      .o_tx_clk_n   (o_tx_clk_n),
      .o_tx_frame_p (o_tx_frame_p),
      .o_tx_frame_n (o_tx_frame_n),
      .o_tx_d_p     (o_tx_d_p),
      .o_tx_d_n     (o_tx_d_n)
   );

endmodule

// File: tb/tb_dac_tx.sv
`timescale 1ns/1ps

module tb_dac_tx
   import dac_if_pkg::*;
();

   localparam int FIFO_DEPTH = 8;
   // 64 unity, 3 gain batches of 24, 40 around the pause
   localparam int N_SAMPLES = 176;
   localparam int TIMEOUT_NS = (N_SAMPLES + 200) * 100;
   localparam int DRAIN_CYCLES = 12;
   // One sync holds frame for the I word plus four more
   localparam int SYNC_WORDS = 5;

   logic      tx_clk_1x;
   logic      tx_clk_2x;
   logic      reset;
   logic      i_s_valid;
   sample_t   i_s_i;
   sample_t   i_s_q;
   gain_t     i_gain_i;
   gain_t     i_gain_q;
   logic      i_sync_dacs;
   logic      o_credit;
   logic      o_underrun;
   logic      o_tx_clk_p;
   logic      o_tx_clk_n;
   logic      o_tx_frame_p;
   logic      o_tx_frame_n;
   dac_byte_t o_tx_d_p;
   dac_byte_t o_tx_d_n;

   // Host model state
   integer seed;
   integer credits;
   integer written;
   integer credit_pulses;
   integer underruns;
   // Result counters
   integer mismatches;
   integer errors;
   integer pair_count;
   // Capture state
   integer gap_runs;
   integer pending_zeros;
   integer sync_runs;
   integer high_run;
   integer low_run;
   logic   frame_seen;
   logic   nonzero_seen;
   logic   prev_frame;
   logic   hi_frame;
   logic [15:0] prev_word;
   logic [15:0] word;
   dac_byte_t   hi_byte;
   dac_byte_t   lo_byte;
   logic [31:0] cmp_got;
   logic [31:0] cmp_want;
   // Pairs packed as {I, Q}
   logic [31:0] exp_q [$];
   logic [31:0] got_q [$];

   dac_tx_top #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_dac_tx_top (
      .tx_clk_1x    (tx_clk_1x),
      .tx_clk_2x    (tx_clk_2x),
      .reset        (reset),
      .i_s_valid    (i_s_valid),
      .i_s_i        (i_s_i),
      .i_s_q        (i_s_q),
      .i_gain_i     (i_gain_i),
      .i_gain_q     (i_gain_q),
      .i_sync_dacs  (i_sync_dacs),
      .o_credit     (o_credit),
      .o_underrun   (o_underrun),
      .o_tx_clk_p   (o_tx_clk_p),
      .o_tx_clk_n   (o_tx_clk_n),
      .o_tx_frame_p (o_tx_frame_p),
      .o_tx_frame_n (o_tx_frame_n),
      .o_tx_d_p     (o_tx_d_p),
      .o_tx_d_n     (o_tx_d_n)
   );

   // 2x starts high so both clocks rise together
   always #50 tx_clk_1x = ~tx_clk_1x;
   always #25 tx_clk_2x = ~tx_clk_2x;

   // Expected DAC word
   // Product plus half an LSB, floor divide by 2^14, clamp to 16 bits
   function automatic sample_t scale_ref(input sample_t s, input gain_t g);
      longint num;
      longint q;
      num = longint'(s) * longint'(g) + 64'sd8192;
      q = num / 16384;
      // Integer division truncates toward zero
      if (((num % 16384) != 0) && (num < 0))
         q = q - 1;
      if (q > 32767)
         q = 32767;
      else if (q < -32768)
         q = -32768;
      return sample_t'(q);
   endfunction

   // Corner samples for the gain batches
   function automatic sample_t extreme_value(input int k);
      case (k)
         0:       return 16'sh7fff;
         1:       return 16'sh8000;
         2:       return 16'sh8001;
         3:       return 16'sd1;
         4:       return -16'sd1;
         5:       return 16'sd16384;
         6:       return -16'sd16384;
         default: return 16'sd2;
      endcase
   endfunction

   // Random sample, zero is reserved for underrun filler
   task automatic next_sample(output sample_t s);
      s = sample_t'($random(seed));
      while (s == 16'sd0)
         s = sample_t'($random(seed));
   endtask

   // Advance to 1 ns after the next 1x edge and collect the feedback
   task automatic next_cycle();
      @(posedge tx_clk_1x);
      #1;
      if (o_credit)
      begin
         credits++;
         credit_pulses++;
      end
      if (o_underrun)
         underruns++;
      if (credits > FIFO_DEPTH)
      begin
         mismatches++;
         $display("mismatch at %0t ns: host holds %0d credits", $time, credits);
      end
   endtask

   task automatic idle_cycles(input int n);
      i_s_valid = 1'b0;
      repeat (n) next_cycle();
   endtask

   // One write, one credit
   task automatic send_pair(input sample_t si, input sample_t sq);
      sample_t ei;
      sample_t eq;
      while (credits == 0)
      begin
         errors++;
         $display("host ran out of credits at %0t ns", $time);
         idle_cycles(1);
      end
      ei = scale_ref(si, i_gain_i);
      eq = scale_ref(sq, i_gain_q);
      // An all-zero result looks like filler on the pins
      if ((ei != 16'sd0) || (eq != 16'sd0))
         exp_q.push_back({ei, eq});
      i_s_valid = 1'b1;
      i_s_i     = si;
      i_s_q     = sq;
      credits--;
      written++;
      next_cycle();
      i_s_valid = 1'b0;
   endtask

   task automatic run_gain_batch(input gain_t gi, input gain_t gq);
      sample_t si;
      sample_t sq;
      i_gain_i = gi;
      i_gain_q = gq;
      for (int k = 0; k < 8; k++)
         send_pair(extreme_value(k), extreme_value(7 - k));
      for (int k = 0; k < 16; k++)
      begin
         next_sample(si);
         next_sample(sq);
         send_pair(si, sq);
      end
      idle_cycles(DRAIN_CYCLES);
   endtask

   // Forwarded clock level and differential complements
   task automatic check_pins(input logic clk_level);
      if (o_tx_clk_p !== clk_level)
      begin
         mismatches++;
         $display("mismatch at %0t ns: tx_clk_p is %b, expected %b", $time, o_tx_clk_p,
                  clk_level);
      end
      if ((o_tx_clk_n !== ~o_tx_clk_p) || (o_tx_frame_n !== ~o_tx_frame_p) ||
          (o_tx_d_n !== ~o_tx_d_p))
      begin
         mismatches++;
         $display("mismatch at %0t ns: an n pin is not the complement of its p pin", $time);
      end
   endtask

   // Runs of frame words, high must be 1 or a single sync run
   task automatic track_frame(input logic fr);
      if (fr === 1'b1)
      begin
         // Low run length is judged on the first high word only
         if (frame_seen && (high_run == 0) && (low_run != 1))
         begin
            mismatches++;
            $display("mismatch at %0t ns: frame low for %0d words", $time, low_run);
         end
         frame_seen = 1'b1;
         low_run    = 0;
         high_run++;
      end
      else
      begin
         if (high_run == SYNC_WORDS)
            sync_runs++;
         else if (high_run > 1)
         begin
            mismatches++;
            $display("mismatch at %0t ns: frame high for %0d words", $time, high_run);
         end
         high_run = 0;
         if (frame_seen)
            low_run++;
      end
   endtask

   // Word capture in the middle of each 2x half
   initial
   begin
      wait (reset == 1'b0);
      forever
      begin
         @(posedge tx_clk_2x);
         #12;
         hi_byte  = o_tx_d_p;
         hi_frame = o_tx_frame_p;
         check_pins(1'b1);
         @(negedge tx_clk_2x);
         #12;
         lo_byte = o_tx_d_p;
         check_pins(1'b0);
         if (o_tx_frame_p !== hi_frame)
         begin
            mismatches++;
            $display("mismatch at %0t ns: frame changed inside a word", $time);
         end
         track_frame(hi_frame);
         word = {hi_byte, lo_byte};
         // I word then Q word
         if (prev_frame && !hi_frame)
         begin
            if ({prev_word, word} == 32'd0)
               pending_zeros++;
            else
            begin
               // Zeros between two real pairs form a gap
               if (nonzero_seen && (pending_zeros > 0))
                  gap_runs++;
               pending_zeros = 0;
               nonzero_seen  = 1'b1;
               got_q.push_back({prev_word, word});
            end
         end
         prev_frame = hi_frame;
         prev_word  = word;
      end
   end

   // In-order compare of captured pairs
   always @(posedge tx_clk_2x)
   begin
      while (got_q.size() > 0)
      begin
         cmp_got = got_q.pop_front();
         pair_count++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("pair I=%0d Q=%0d arrived at %0t ns when none was expected",
                     $signed(cmp_got[31:16]), $signed(cmp_got[15:0]), $time);
         end
         else
         begin
            cmp_want = exp_q.pop_front();
            if (cmp_got != cmp_want)
            begin
               mismatches++;
               $display("mismatch at %0t ns: pair %0d got I=%0d Q=%0d, expected I=%0d Q=%0d",
                        $time, pair_count, $signed(cmp_got[31:16]), $signed(cmp_got[15:0]),
                        $signed(cmp_want[31:16]), $signed(cmp_want[15:0]));
            end
         end
      end
   end

   // Watchdog
   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout after %0d ns, the test sequence did not finish", TIMEOUT_NS);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin : main
      sample_t si;
      sample_t sq;
      integer  u0;
      integer  g0;
      // Times in messages are printed in ns
      $timeformat(-9, 0, "", 0);
      tx_clk_1x     = 1'b0;
      tx_clk_2x     = 1'b1;
      reset         = 1'b1;
      i_s_valid     = 1'b0;
      i_s_i         = '0;
      i_s_q         = '0;
      i_gain_i      = 16'sd16384;
      i_gain_q      = 16'sd16384;
      i_sync_dacs   = 1'b0;
      seed          = 93;
      credits       = FIFO_DEPTH;
      written       = 0;
      credit_pulses = 0;
      underruns     = 0;
      mismatches    = 0;
      errors        = 0;
      pair_count    = 0;
      gap_runs      = 0;
      pending_zeros = 0;
      sync_runs     = 0;
      high_run      = 0;
      low_run       = 0;
      frame_seen    = 1'b0;
      nonzero_seen  = 1'b0;
      prev_frame    = 1'b0;
      prev_word     = '0;
      repeat (3) @(posedge tx_clk_1x);
      #1;
      reset = 1'b0;
      idle_cycles(4);

      // Full rate stream at unity gain, one underrun at the end only
      u0 = underruns;
      g0 = gap_runs;
      repeat (64)
      begin
         next_sample(si);
         next_sample(sq);
         send_pair(si, sq);
      end
      idle_cycles(DRAIN_CYCLES);
      if ((underruns - u0) != 1)
      begin
         mismatches++;
         $display("mismatch at %0t ns: %0d underruns in the stream", $time, underruns - u0);
      end
      if (gap_runs != g0)
      begin
         mismatches++;
         $display("mismatch at %0t ns: zero gap inside the stream", $time);
      end

      // Gains of 0.5, -1.0 and 1.99 with rounding and clamping
      run_gain_batch(16'sd8192, -16'sd16384);
      run_gain_batch(16'sd32604, 16'sd8192);
      run_gain_batch(-16'sd16384, 16'sd32604);

      // Host pause in the middle of a stream
      i_gain_i = 16'sd16384;
      i_gain_q = 16'sd16384;
      u0 = underruns;
      g0 = gap_runs;
      repeat (20)
      begin
         next_sample(si);
         next_sample(sq);
         send_pair(si, sq);
      end
      idle_cycles(10);
      repeat (20)
      begin
         next_sample(si);
         next_sample(sq);
         send_pair(si, sq);
      end
      idle_cycles(DRAIN_CYCLES);
      // Gap left by the previous drain plus the pause
      if (((underruns - u0) != 2) || ((gap_runs - g0) != 2))
      begin
         mismatches++;
         $display("mismatch at %0t ns: %0d underruns and %0d gaps around the pause", $time,
                  underruns - u0, gap_runs - g0);
      end

      // One sync request while idle
      i_sync_dacs = 1'b1;
      idle_cycles(3);
      i_sync_dacs = 1'b0;
      idle_cycles(15);
      if (sync_runs != 1)
      begin
         mismatches++;
         $display("mismatch at %0t ns: %0d sync frame runs", $time, sync_runs);
      end

      // Credits all returned
      if ((credit_pulses != written) || (credits != FIFO_DEPTH))
      begin
         mismatches++;
         $display("mismatch at %0t ns: %0d credits for %0d writes, host holds %0d", $time,
                  credit_pulses, written, credits);
      end
      if (exp_q.size() != 0)
      begin
         errors++;
         $display("%0d expected pairs never reached the DAC pins", exp_q.size());
      end

      $display("pairs checked %0d, mismatches %0d, other errors %0d", pair_count, mismatches,
               errors);
      if ((mismatches == 0) && (errors == 0))
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: sim.f
common/dac_if_pkg.sv
common/tx_ctrl_pkg.sv
source/sample_credit_rx.sv
source/iq_gain_scaler.sv
ddr_lvds/frame_sync_gen.sv
ddr_lvds/ddr_lvds_tx.sv
source/dac_tx_top.sv
tb/tb_dac_tx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DAC transmit path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module tb_dac_tx \
   -f sim.f \
   -o tb_dac_tx

./obj_dir/tb_dac_tx > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
